/* Bender.yml */
package:
  name: gate_preact

sources:
  - src/lstm_pkg.sv
  - src/fxp_mul.sv
  - src/vecmat_mul.sv
  - src/vecmat_add.sv
  - src/vecmat_dot.sv
  - src/gate_sum.sv
  - src/gate_preact.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/gate_preact_tb.sv

/* list.f */
+incdir+verif
src/lstm_pkg.sv
src/fxp_mul.sv
src/vecmat_mul.sv
src/vecmat_add.sv
src/vecmat_dot.sv
src/gate_sum.sv
src/gate_preact.sv
verif/gate_preact_tb.sv

/* src/fxp_mul.sv */
`timescale 1ns/1ps

module fxp_mul
	import lstm_pkg::*;
(
	input  logic                         clk,
	input  logic signed [DATA_WIDTH-1:0] a,
	input  logic signed [DATA_WIDTH-1:0] b,
	output logic signed [DATA_WIDTH-1:0] c
);

	logic signed [2*DATA_WIDTH-1:0] full;
	logic signed [2*DATA_WIDTH-1:0] shifted;

	assign full = a * b;
	assign shifted = full >>> FRAC_BITS; // rounds toward minus infinity

	// keep the low bits, upper ones wrap away
	always_ff @(posedge clk) begin
		c <= shifted[DATA_WIDTH-1:0];
	end

endmodule

/* src/gate_preact.sv */
`timescale 1ns/1ps

module gate_preact
	import lstm_pkg::*;
(
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               load,
	input  logic [INPUT_DEPTH*DATA_WIDTH-1:0]  data_x,
	input  logic [INPUT_DEPTH*DATA_WIDTH-1:0]  w_x,
	input  logic [HIDDEN_DEPTH*DATA_WIDTH-1:0] data_h,
	input  logic [HIDDEN_DEPTH*DATA_WIDTH-1:0] u_h,
	input  logic [DATA_WIDTH-1:0]              bias,
	output logic [DATA_WIDTH-1:0]              data_out,
	output logic                               valid
);

	logic signed [ACC_WIDTH-1:0] sum_x;
	logic signed [ACC_WIDTH-1:0] sum_h;

	// input path, W * x
	vecmat_dot #(
		.vect_len (INPUT_DEPTH)
	) x_dot_i (
		.clk  (clk),
		.load (load),
		.data (data_x),
		.w    (w_x),
		.sum  (sum_x)
	);

	// recurrent path, U * h
	// same tree depth as the input path so the sums line up
	vecmat_dot #(
		.vect_len (HIDDEN_DEPTH)
	) h_dot_i (
		.clk  (clk),
		.load (load),
		.data (data_h),
		.w    (u_h),
		.sum  (sum_h)
	);

	gate_sum sum_i (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.bias     (bias),
		.sum_x    (sum_x),
		.sum_h    (sum_h),
		.data_out (data_out),
		.valid    (valid)
	);

endmodule

/* src/gate_sum.sv */
`timescale 1ns/1ps

module gate_sum
	import lstm_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        load,
	input  logic [DATA_WIDTH-1:0]       bias,
	input  logic signed [ACC_WIDTH-1:0] sum_x,
	input  logic signed [ACC_WIDTH-1:0] sum_h,
	output logic [DATA_WIDTH-1:0]       data_out,
	output logic                        valid
);

	logic [DOT_LATENCY-1:0]  load_dly;
	logic [DATA_WIDTH-1:0]   bias_dly [DOT_LATENCY];
	logic signed [SUM_WIDTH-1:0] total;
	logic                    in_range;
	logic [DATA_WIDTH-1:0]   sat;

	// load travels alongside the dot pipelines
	always_ff @(posedge clk) begin
		if (!reset) begin
			load_dly <= '0;
		end else begin
			load_dly <= {load_dly[DOT_LATENCY-2:0], load};
		end
	end

	always_ff @(posedge clk) begin
		bias_dly[0] <= bias;
		for (int i = 1; i < DOT_LATENCY; i++) begin
			bias_dly[i] <= bias_dly[i-1];
		end
	end

	assign total = SUM_WIDTH'(sum_x) + SUM_WIDTH'(sum_h) + {
		{(SUM_WIDTH-DATA_WIDTH){bias_dly[DOT_LATENCY-1][DATA_WIDTH-1]}},
		bias_dly[DOT_LATENCY-1]
	};

	// fits in 16 bits when the bits above the sign all match it
	assign in_range = (&total[SUM_WIDTH-1:DATA_WIDTH-1]) |
		~(|total[SUM_WIDTH-1:DATA_WIDTH-1]);
	assign sat = in_range ? total[DATA_WIDTH-1:0] :
		{total[SUM_WIDTH-1], {(DATA_WIDTH-1){~total[SUM_WIDTH-1]}}}; // clamp by sign

	always_ff @(posedge clk) begin
		data_out <= sat;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			valid <= 1'b0;
		end else begin
			valid <= load_dly[DOT_LATENCY-1];
		end
	end

endmodule

/* src/lstm_pkg.sv */
package lstm_pkg;

	// q8.8 fixed point
	localparam int DATA_WIDTH = 16;
	localparam int FRAC_BITS = 8;

	// vector lengths, cut down for simulation
	localparam int INPUT_DEPTH = 16;
	localparam int HIDDEN_DEPTH = 8;

	// adder tree shared by both paths
	localparam int ADD_LEVELS = 4;
	localparam int TREE_LEN = 1 << ADD_LEVELS; // leaves incl. zero padding

	// exact dot sum, one growth bit per tree level
	localparam int ACC_WIDTH = DATA_WIDTH + ADD_LEVELS;

	// sum_x + sum_h + bias before saturation
	localparam int SUM_WIDTH = ACC_WIDTH + 2;

	// capture + multiply + tree
	localparam int DOT_LATENCY = 2 + ADD_LEVELS;

endpackage

/* src/vecmat_add.sv */
`timescale 1ns/1ps

module vecmat_add
	import lstm_pkg::*;
#(
	parameter int vect_len = INPUT_DEPTH
)
(
	input  logic                           clk,
	input  logic [vect_len*DATA_WIDTH-1:0] prod,
	output logic signed [ACC_WIDTH-1:0]    sum
);

	// leaves are the sign-extended products plus zero padding
	logic signed [ACC_WIDTH-1:0] leaf [TREE_LEN];

	// heap order: node n adds children 2n+1 and 2n+2, root is node 0
	logic signed [ACC_WIDTH-1:0] node [TREE_LEN-1];

	genvar j, n;
	generate
		for (j = 0; j < TREE_LEN; j++) begin : g_leaf
			if (j < vect_len) begin : g_prod
				assign leaf[j] = {
					{(ACC_WIDTH-DATA_WIDTH){prod[j*DATA_WIDTH+DATA_WIDTH-1]}},
					prod[j*DATA_WIDTH +: DATA_WIDTH]
				};
			end else begin : g_pad
				assign leaf[j] = '0;
			end
		end

		// one register per tree level, the root lands ADD_LEVELS cycles after prod
		for (n = 0; n < TREE_LEN-1; n++) begin : g_node
			if (2*n+1 >= TREE_LEN-1) begin : g_bottom
				always_ff @(posedge clk) begin
					node[n] <= leaf[2*n+1-(TREE_LEN-1)] + leaf[2*n+2-(TREE_LEN-1)];
				end
			end else begin : g_inner
				always_ff @(posedge clk) begin
					node[n] <= node[2*n+1] + node[2*n+2];
				end
			end
		end
	endgenerate

	assign sum = node[0];

endmodule

/* src/vecmat_dot.sv */
`timescale 1ns/1ps

module vecmat_dot
	import lstm_pkg::*;
#(
	parameter int vect_len = INPUT_DEPTH
)
(
	input  logic                           clk,
	input  logic                           load,
	input  logic [vect_len*DATA_WIDTH-1:0] data,
	input  logic [vect_len*DATA_WIDTH-1:0] w,
	output logic signed [ACC_WIDTH-1:0]    sum
);

	logic [vect_len*DATA_WIDTH-1:0] prod;

	// capture and multiply, two cycles
	vecmat_mul #(
		.vect_len (vect_len)
	) mul_i (
		.clk  (clk),
		.load (load),
		.data (data),
		.w    (w),
		.prod (prod)
	);

	// ADD_LEVELS more cycles to the dot sum
	vecmat_add #(
		.vect_len (vect_len)
	) add_i (
		.clk  (clk),
		.prod (prod),
		.sum  (sum)
	);

endmodule

/* src/vecmat_mul.sv */
`timescale 1ns/1ps

module vecmat_mul
	import lstm_pkg::*;
#(
	parameter int vect_len = INPUT_DEPTH
)
(
	input  logic                             clk,
	input  logic                             load,
	input  logic [vect_len*DATA_WIDTH-1:0]   data,
	input  logic [vect_len*DATA_WIDTH-1:0]   w,
	output logic [vect_len*DATA_WIDTH-1:0]   prod
);

	logic [vect_len*DATA_WIDTH-1:0] vector_q;
	logic [vect_len*DATA_WIDTH-1:0] matrix_q;

	// operand capture, held between loads
	always_ff @(posedge clk) begin
		if (load) begin
			vector_q <= data;
			matrix_q <= w;
		end
	end

	// one multiplier per element
	genvar j;
	generate
		for (j = 0; j < vect_len; j++) begin : g_mul
			fxp_mul mul_i (
				.clk (clk),
				.a   (vector_q[j*DATA_WIDTH +: DATA_WIDTH]),
				.b   (matrix_q[j*DATA_WIDTH +: DATA_WIDTH]),
				.c   (prod[j*DATA_WIDTH +: DATA_WIDTH])
			);
		end
	endgenerate

endmodule

/* verif/gate_ref.svh */
`ifndef GATE_REF_SVH
`define GATE_REF_SVH

// one step of a 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// products shifted and wrapped like the hardware, then summed exactly
function automatic longint ref_dot(
	input logic [lstm_pkg::INPUT_DEPTH*lstm_pkg::DATA_WIDTH-1:0] data,
	input logic [lstm_pkg::INPUT_DEPTH*lstm_pkg::DATA_WIDTH-1:0] w,
	input int len
);
	longint acc;
	logic signed [lstm_pkg::DATA_WIDTH-1:0] a;
	logic signed [lstm_pkg::DATA_WIDTH-1:0] b;
	logic signed [2*lstm_pkg::DATA_WIDTH-1:0] p;
	acc = 0;
	for (int i = 0; i < len; i++) begin
		a = data[i*lstm_pkg::DATA_WIDTH +: lstm_pkg::DATA_WIDTH];
		b = w[i*lstm_pkg::DATA_WIDTH +: lstm_pkg::DATA_WIDTH];
		p = a * b;
		p = p >>> lstm_pkg::FRAC_BITS;
		acc += longint'(signed'(p[lstm_pkg::DATA_WIDTH-1:0]));
	end
	return acc;
endfunction

// clamp to the signed 16-bit range
function automatic logic [15:0] ref_sat(input longint v);
	if (v > 32767)
		return 16'h7fff;
	if (v < -32768)
		return 16'h8000;
	return v[15:0];
endfunction

`endif

/* verif/gate_preact_tb.sv */
`timescale 1ns/1ps

module gate_preact_tb
	import lstm_pkg::*;
();

	`include "gate_ref.svh"

	localparam int XW = INPUT_DEPTH*DATA_WIDTH;
	localparam int HW = HIDDEN_DEPTH*DATA_WIDTH;
	localparam int N_RANDOM = 200;
	localparam int N_SPARSE = 20;
	localparam int MAX_GAP = 7;
	localparam int N_BIAS = 30;
	localparam int N_FIXED = 1 + 5 + 3; // single, saturation, rounding
	localparam int DRAIN_CYCLES = 15;
	localparam int NUM_LOADS = N_FIXED + N_RANDOM + N_SPARSE + N_BIAS;
	localparam int IDLE_CYCLES = 4 + 5 + N_SPARSE*MAX_GAP + 6*DRAIN_CYCLES;

	logic clk;
	logic reset;
	logic load;
	logic [XW-1:0] data_x;
	logic [XW-1:0] w_x;
	logic [HW-1:0] data_h;
	logic [HW-1:0] u_h;
	logic [DATA_WIDTH-1:0] bias;
	logic [DATA_WIDTH-1:0] data_out;
	logic valid;

	logic [31:0] lfsr_state;
	int cycle_cnt;
	int value_errors;
	int other_errors;
	logic [DATA_WIDTH-1:0] exp_q [$];
	int due_q [$];

	gate_preact dut_i (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.data_x   (data_x),
		.w_x      (w_x),
		.data_h   (data_h),
		.u_h      (u_h),
		.bias     (bias),
		.data_out (data_out),
		.valid    (valid)
	);

	always #5 clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// collect n lfsr bits, one step each
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// signed element from a bits-wide random field
	function automatic logic [DATA_WIDTH-1:0] rand_elem(input int bits);
		int v;
		v = int'(take_bits(bits) << (32 - bits)) >>> (32 - bits);
		return v[DATA_WIDTH-1:0];
	endfunction

	function automatic logic [DATA_WIDTH-1:0] gate_expected(
		input logic [XW-1:0] x,
		input logic [XW-1:0] wx,
		input logic [HW-1:0] h,
		input logic [HW-1:0] uh,
		input logic [DATA_WIDTH-1:0] b
	);
		logic [XW-1:0] h_pad;
		logic [XW-1:0] u_pad;
		h_pad = '0;
		u_pad = '0;
		h_pad[HW-1:0] = h;
		u_pad[HW-1:0] = uh;
		return ref_sat(ref_dot(x, wx, INPUT_DEPTH) + ref_dot(h_pad, u_pad, HIDDEN_DEPTH) +
			longint'($signed(b)));
	endfunction

	task automatic check_value(input string name, input logic signed [31:0] got,
		input logic signed [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0d ns %s got %0d expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// called 1 ns after a rising edge, returns 1 ns after the next one
	task automatic drive_load(input logic [XW-1:0] x, input logic [XW-1:0] wx,
		input logic [HW-1:0] h, input logic [HW-1:0] uh, input logic [DATA_WIDTH-1:0] b);
		load = 1'b1;
		data_x = x;
		w_x = wx;
		data_h = h;
		u_h = uh;
		bias = b;
		exp_q.push_back(gate_expected(x, wx, h, uh, b));
		due_q.push_back(cycle_cnt + 7); // valid 7 edges after the drive edge
		@(posedge clk);
		#1;
	endtask

	task automatic drive_idle(input int n);
		load = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_drain();
		int waited;
		load = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d ns: %0d results never came out", $time, exp_q.size());
			other_errors++;
			exp_q.delete();
			due_q.delete();
		end
	endtask

	task automatic random_operands(input int bits, output logic [XW-1:0] x,
		output logic [XW-1:0] wx, output logic [HW-1:0] h, output logic [HW-1:0] uh,
		output logic [DATA_WIDTH-1:0] b);
		for (int i = 0; i < INPUT_DEPTH; i++) begin
			x[i*DATA_WIDTH +: DATA_WIDTH] = rand_elem(bits);
			wx[i*DATA_WIDTH +: DATA_WIDTH] = rand_elem(bits);
		end
		for (int i = 0; i < HIDDEN_DEPTH; i++) begin
			h[i*DATA_WIDTH +: DATA_WIDTH] = rand_elem(bits);
			uh[i*DATA_WIDTH +: DATA_WIDTH] = rand_elem(bits);
		end
		b = rand_elem(DATA_WIDTH);
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (reset && valid) begin
			if (exp_q.size() == 0) begin
				$display("%0d ns: valid pulse with no load pending", $time);
				other_errors++;
			end else begin
				check_value("valid cycle", cycle_cnt, due_q.pop_front());
				check_value("data_out", $signed(data_out), $signed(exp_q.pop_front()));
			end
		end
	end

	initial begin
		#((NUM_LOADS + IDLE_CYCLES + 50) * 10);
		$display("watchdog expired, simulation did not finish in time");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [XW-1:0] x;
		logic [XW-1:0] wx;
		logic [HW-1:0] h;
		logic [HW-1:0] uh;
		logic [DATA_WIDTH-1:0] b;

		clk = 1'b0;
		reset = 1'b0;
		load = 1'b0;
		data_x = '0;
		w_x = '0;
		data_h = '0;
		u_h = '0;
		bias = '0;
		cycle_cnt = 0;
		value_errors = 0;
		other_errors = 0;
		lfsr_state = 32'h8b75;

		repeat (4) @(posedge clk);
		#1;
		reset = 1'b1;

		// quiet after reset, then one load
		repeat (5) begin
			check_value("valid", valid, 0);
			drive_idle(1);
		end
		random_operands(12, x, wx, h, uh, b);
		drive_load(x, wx, h, uh, b);
		wait_drain();

		for (int n = 0; n < N_RANDOM; n++) begin
			random_operands(12, x, wx, h, uh, b);
			drive_load(x, wx, h, uh, b);
		end
		wait_drain();

		for (int n = 0; n < N_SPARSE; n++) begin
			drive_idle(take_bits(3));
			random_operands(12, x, wx, h, uh, b);
			drive_load(x, wx, h, uh, b);
		end
		wait_drain();

		// saturation, both signs and the edge of range
		wx = {INPUT_DEPTH{16'h0100}};
		uh = {HIDDEN_DEPTH{16'h0100}};
		drive_load({INPUT_DEPTH{16'h7fff}}, wx, {HIDDEN_DEPTH{16'h7fff}}, uh, 16'h7fff);
		drive_load({INPUT_DEPTH{16'h8000}}, wx, {HIDDEN_DEPTH{16'h8000}}, uh, 16'h8000);
		drive_load('0, wx, '0, uh, 16'h7fff);
		drive_load({{(INPUT_DEPTH-1){16'h0000}}, 16'h0001}, wx, '0, uh, 16'h7fff);
		drive_load({{(INPUT_DEPTH-1){16'h0000}}, 16'hffff}, wx, '0, uh, 16'h8000);
		wait_drain();

		// floor on negative products, 16-bit wrap of -128 * -128
		for (int i = 0; i < INPUT_DEPTH; i++) begin
			x[i*DATA_WIDTH +: DATA_WIDTH] = 16'(-(i*53 + 7));
			wx[i*DATA_WIDTH +: DATA_WIDTH] = 16'(16'h0100 + i*19);
		end
		drive_load(x, wx, {HIDDEN_DEPTH{16'h8000}}, {HIDDEN_DEPTH{16'h8000}}, 16'h0000);
		drive_load(x, {INPUT_DEPTH{16'h0080}}, '0, '0, 16'h0000);
		drive_load({INPUT_DEPTH{16'hffff}}, {INPUT_DEPTH{16'h0001}}, '0, '0, 16'h0000);
		wait_drain();

		// zero weights, result is the bias of the same load
		for (int n = 0; n < N_BIAS; n++) begin
			random_operands(16, x, wx, h, uh, b);
			drive_load(x, '0, h, '0, b);
		end
		wait_drain();

		if (exp_q.size() != 0) begin
			$display("%0d expected results were left over at the end", exp_q.size());
			other_errors++;
		end
		$display("errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
